// File: logic/aximm_stream_server.sv
`timescale 1ns/1ps
`default_nettype none

// Memory-mapped access server over a stream FIFO
module aximm_stream_server (
    input  wire                       clk,
    input  wire                       resetn,

    // FIFO register bus, one access at a time
    output wire bus_pkg::fifo_addr_t  fifo_addr,
    output wire pkt_pkg::pkt_word_t   fifo_wdata,
    output wire                       fifo_write,
    output wire                       fifo_read,
    input  wire pkt_pkg::pkt_word_t   fifo_rdata,
    input  wire                       fifo_done,

    // System bus write channel
    output wire bus_pkg::sys_addr_t   sys_wr_addr,
    output wire bus_pkg::sys_data_t   sys_wr_data,
    output wire                       sys_write,
    input  wire                       sys_wr_done,
    input  wire bus_pkg::bus_resp_t   sys_wr_resp,

    // System bus read channel
    output wire bus_pkg::sys_addr_t   sys_rd_addr,
    output wire                       sys_read,
    input  wire                       sys_rd_done,
    input  wire bus_pkg::sys_data_t   sys_rd_data,
    input  wire bus_pkg::bus_resp_t   sys_rd_resp
);

    server_link_if link ();

    // FIFO side
    fifo_packet_engine engine (
        .clk        (clk),
        .resetn     (resetn),
        .link       (link.engine),
        .fifo_addr  (fifo_addr),
        .fifo_wdata (fifo_wdata),
        .fifo_write (fifo_write),
        .fifo_read  (fifo_read),
        .fifo_rdata (fifo_rdata),
        .fifo_done  (fifo_done)
    );

    // System side
    system_access_engine executor (
        .clk         (clk),
        .resetn      (resetn),
        .link        (link.executor),
        .sys_wr_addr (sys_wr_addr),
        .sys_wr_data (sys_wr_data),
        .sys_write   (sys_write),
        .sys_wr_done (sys_wr_done),
        .sys_wr_resp (sys_wr_resp),
        .sys_rd_addr (sys_rd_addr),
        .sys_read    (sys_read),
        .sys_rd_done (sys_rd_done),
        .sys_rd_data (sys_rd_data),
        .sys_rd_resp (sys_rd_resp)
    );

endmodule

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

// Widths and register map of the FIFO bus and the system bus
package bus_pkg;

    // FIFO register address
    typedef logic [31:0] fifo_addr_t;

    // System side, ADRH forms the upper half of the address
    typedef logic [63:0] sys_addr_t;
    typedef logic [31:0] sys_data_t;
    typedef logic [1:0]  bus_resp_t;

    // Response codes
    localparam bus_resp_t RESP_OKAY   = 2'd0;
    localparam bus_resp_t RESP_SLVERR = 2'd2;

    // Stream FIFO register offsets
    localparam fifo_addr_t ASF_TDATA = 32'h10;
    localparam fifo_addr_t ASF_TLR   = 32'h14;
    localparam fifo_addr_t ASF_RDFO  = 32'h1C;
    localparam fifo_addr_t ASF_RDATA = 32'h20;

endpackage

`default_nettype wire

// File: logic/fifo_packet_engine.sv
`timescale 1ns/1ps
`default_nettype none

// Polls the stream FIFO, pulls in request packets and pushes out responses
module fifo_packet_engine (
    input  wire                       clk,
    input  wire                       resetn,
    server_link_if.engine             link,
    output bus_pkg::fifo_addr_t       fifo_addr,
    output pkt_pkg::pkt_word_t        fifo_wdata,
    output logic                      fifo_write,
    output logic                      fifo_read,
    input  wire pkt_pkg::pkt_word_t   fifo_rdata,
    input  wire                       fifo_done
);

    typedef enum logic [2:0] {
        IDLE,
        POLL,
        FETCH,
        ISSUE,
        SEND,
        COMMIT,
        WAIT_COMMIT
    } engine_state_e;

    engine_state_e        state;
    pkt_pkg::pkt_index_t  word_idx;

    // Request fields gathered while fetching
    logic                 req_read;
    bus_pkg::sys_addr_t   req_addr;
    bus_pkg::sys_data_t   req_wdata;

    // Response fields copied from the executor
    bus_pkg::sys_addr_t   resp_addr;
    bus_pkg::sys_data_t   resp_data;
    bus_pkg::bus_resp_t   resp_code;
    pkt_pkg::pkt_word_t   resp_word;

    // A FIFO access is in flight
    logic                 access_open;

    // Request strobe lasts exactly the one ISSUE cycle
    assign link.wr_req    = (state == ISSUE) && !req_read;
    assign link.rd_req    = (state == ISSUE) && req_read;
    assign link.req_addr  = req_addr;
    assign link.req_wdata = req_wdata;

    // Response word for the current index
    // Word 0 goes out straight from IDLE
    // Words 5 to 7 are zero
    always_comb begin
        case (word_idx)
            pkt_pkg::PF_ADRH: resp_word = resp_addr[63:32];
            pkt_pkg::PF_ADRL: resp_word = resp_addr[31:0];
            pkt_pkg::PF_DATA: resp_word = resp_data;
            pkt_pkg::PF_RESP: resp_word = pkt_pkg::pkt_word_t'(resp_code);
            default:          resp_word = '0;
        endcase
    end

    // ==========================================================================
    // Main FSM
    // ==========================================================================
    always_ff @(posedge clk) begin
        // Strobes last one cycle
        fifo_read    <= 1'b0;
        fifo_write   <= 1'b0;
        link.wr_take <= 1'b0;
        link.rd_take <= 1'b0;

        if (!resetn) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Finished writes go out first, then reads
                    if (link.wr_pending) begin
                        resp_addr    <= link.wr_addr;
                        resp_data    <= link.wr_data;
                        resp_code    <= link.wr_resp;
                        link.wr_take <= 1'b1;
                        fifo_addr    <= bus_pkg::ASF_TDATA;
                        fifo_wdata   <= pkt_pkg::pkt_word_t'(pkt_pkg::PKT_WRITE);
                        fifo_write   <= 1'b1;
                        word_idx     <= pkt_pkg::PF_ADRH;
                        state        <= SEND;
                    end else if (link.rd_pending) begin
                        resp_addr    <= link.rd_addr;
                        resp_data    <= link.rd_data;
                        resp_code    <= link.rd_resp;
                        link.rd_take <= 1'b1;
                        fifo_addr    <= bus_pkg::ASF_TDATA;
                        fifo_wdata   <= pkt_pkg::pkt_word_t'(pkt_pkg::PKT_READ);
                        fifo_write   <= 1'b1;
                        word_idx     <= pkt_pkg::PF_ADRH;
                        state        <= SEND;
                    end else if (!link.wr_busy && !link.rd_busy) begin
                        // Only look for work when both channels can take it
                        fifo_addr <= bus_pkg::ASF_RDFO;
                        fifo_read <= 1'b1;
                        state     <= POLL;
                    end
                end

                POLL: begin
                    if (fifo_done) begin
                        // Non-zero occupancy means a packet is waiting
                        if (fifo_rdata != '0) begin
                            fifo_addr <= bus_pkg::ASF_RDATA;
                            fifo_read <= 1'b1;
                            word_idx  <= pkt_pkg::PF_TYPE;
                            state     <= FETCH;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end

                FETCH: begin
                    if (fifo_done) begin
                        case (word_idx)
                            pkt_pkg::PF_TYPE: begin
                                req_read <= (fifo_rdata ==
                                             pkt_pkg::pkt_word_t'(pkt_pkg::PKT_READ));
                            end
                            pkt_pkg::PF_ADRH: req_addr[63:32] <= fifo_rdata;
                            pkt_pkg::PF_ADRL: req_addr[31:0]  <= fifo_rdata;
                            pkt_pkg::PF_DATA: req_wdata       <= fifo_rdata;
                            default: ;
                        endcase
                        // Trailing words are read and dropped
                        if (word_idx == pkt_pkg::PKT_WORDS - 4'd1) begin
                            state <= ISSUE;
                        end else begin
                            word_idx  <= word_idx + 4'd1;
                            fifo_read <= 1'b1;
                        end
                    end
                end

                ISSUE: begin
                    state <= IDLE;
                end

                SEND: begin
                    if (fifo_done) begin
                        if (word_idx == pkt_pkg::PKT_WORDS) begin
                            state <= COMMIT;
                        end else begin
                            fifo_wdata <= resp_word;
                            fifo_write <= 1'b1;
                            word_idx   <= word_idx + 4'd1;
                        end
                    end
                end

                COMMIT: begin
                    // Length write releases the packet onto the stream
                    fifo_addr  <= bus_pkg::ASF_TLR;
                    fifo_wdata <= pkt_pkg::PKT_BYTES;
                    fifo_write <= 1'b1;
                    state      <= WAIT_COMMIT;
                end

                WAIT_COMMIT: begin
                    if (fifo_done) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // ==========================================================================
    // FIFO bus checks
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            access_open <= 1'b0;
        end else if (fifo_read || fifo_write) begin
            access_open <= 1'b1;
        end else if (fifo_done) begin
            access_open <= 1'b0;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(fifo_read && fifo_write));

    // Next access only after the previous one has completed
    a_one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        (fifo_read || fifo_write) |-> !access_open);

endmodule

`default_nettype wire

// File: logic/pkt_pkg.sv
`default_nettype none

// Packet layout shared by requests and responses
package pkt_pkg;

    // One packet word, as seen in the FIFO data registers
    typedef logic [31:0] pkt_word_t;

    // Word counter, wide enough to reach PKT_WORDS itself
    typedef logic [3:0] pkt_index_t;

    // Packet type carried in word 0
    // Anything other than PKT_READ gets served as a write
    typedef enum logic [1:0] {
        PKT_READ  = 2'd1,
        PKT_WRITE = 2'd2
    } pkt_type_e;

    // Length in words, and in bytes for the transmit length register
    localparam pkt_index_t PKT_WORDS = 4'd8;
    localparam pkt_word_t  PKT_BYTES = 32'd32;

    // Field positions inside a packet
    localparam pkt_index_t PF_TYPE = 4'd0;
    localparam pkt_index_t PF_ADRH = 4'd1;
    localparam pkt_index_t PF_ADRL = 4'd2;
    localparam pkt_index_t PF_DATA = 4'd3;
    // Bus response code, words 5 to 7 stay zero
    localparam pkt_index_t PF_RESP = 4'd4;

endpackage

`default_nettype wire

// File: logic/server_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// Link between the packet engine and the system access engine
interface server_link_if;

    // Requests, single-cycle strobes with address and data valid alongside
    logic                wr_req;
    logic                rd_req;
    bus_pkg::sys_addr_t  req_addr;
    bus_pkg::sys_data_t  req_wdata;

    // Engine has copied a finished response
    logic                wr_take;
    logic                rd_take;

    // Channel state as seen by the engine
    logic                wr_busy;
    logic                rd_busy;
    logic                wr_pending;
    logic                rd_pending;

    // Echoed request and the bus result, held while pending
    bus_pkg::sys_addr_t  wr_addr;
    bus_pkg::sys_data_t  wr_data;
    bus_pkg::bus_resp_t  wr_resp;
    bus_pkg::sys_addr_t  rd_addr;
    bus_pkg::sys_data_t  rd_data;
    bus_pkg::bus_resp_t  rd_resp;

    modport engine (
        output wr_req, rd_req, req_addr, req_wdata, wr_take, rd_take,
        input  wr_busy, rd_busy, wr_pending, rd_pending,
        input  wr_addr, wr_data, wr_resp, rd_addr, rd_data, rd_resp
    );

    modport executor (
        input  wr_req, rd_req, req_addr, req_wdata, wr_take, rd_take,
        output wr_busy, rd_busy, wr_pending, rd_pending,
        output wr_addr, wr_data, wr_resp, rd_addr, rd_data, rd_resp
    );

endinterface

`default_nettype wire

// File: logic/system_access_engine.sv
`timescale 1ns/1ps
`default_nettype none

// Write and read executors on the system bus
module system_access_engine (
    input  wire                       clk,
    input  wire                       resetn,
    server_link_if.executor           link,
    output bus_pkg::sys_addr_t        sys_wr_addr,
    output bus_pkg::sys_data_t        sys_wr_data,
    output logic                      sys_write,
    input  wire                       sys_wr_done,
    input  wire bus_pkg::bus_resp_t   sys_wr_resp,
    output bus_pkg::sys_addr_t        sys_rd_addr,
    output logic                      sys_read,
    input  wire                       sys_rd_done,
    input  wire bus_pkg::sys_data_t   sys_rd_data,
    input  wire bus_pkg::bus_resp_t   sys_rd_resp
);

    // ACCESS waits for the bus, HOLD keeps the result until taken
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        HOLD
    } exec_state_e;

    exec_state_e wr_state;
    exec_state_e rd_state;

    // Busy covers both the bus access and the hold
    assign link.wr_busy    = (wr_state != IDLE);
    assign link.rd_busy    = (rd_state != IDLE);
    assign link.wr_pending = (wr_state == HOLD);
    assign link.rd_pending = (rd_state == HOLD);

    // Latched request doubles as the echo
    assign link.wr_addr = sys_wr_addr;
    assign link.wr_data = sys_wr_data;
    assign link.rd_addr = sys_rd_addr;

    // ==========================================================================
    // Write channel
    // ==========================================================================
    always_ff @(posedge clk) begin
        sys_write <= 1'b0;
        if (!resetn) begin
            wr_state <= IDLE;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (link.wr_req) begin
                        sys_wr_addr <= link.req_addr;
                        sys_wr_data <= link.req_wdata;
                        sys_write   <= 1'b1;
                        wr_state    <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (sys_wr_done) begin
                        link.wr_resp <= sys_wr_resp;
                        wr_state     <= HOLD;
                    end
                end
                HOLD: begin
                    if (link.wr_take) begin
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    // ==========================================================================
    // Read channel
    // ==========================================================================
    always_ff @(posedge clk) begin
        sys_read <= 1'b0;
        if (!resetn) begin
            rd_state <= IDLE;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (link.rd_req) begin
                        sys_rd_addr <= link.req_addr;
                        sys_read    <= 1'b1;
                        rd_state    <= ACCESS;
                    end
                end
                ACCESS: begin
                    // Data and code arrive together with done
                    if (sys_rd_done) begin
                        link.rd_data <= sys_rd_data;
                        link.rd_resp <= sys_rd_resp;
                        rd_state     <= HOLD;
                    end
                end
                HOLD: begin
                    if (link.rd_take) begin
                        rd_state <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    // Engine must never hand a request to a channel still working on one
    a_wr_req_idle: assert property (@(posedge clk) disable iff (!resetn)
        link.wr_req |-> !link.wr_busy);
    a_rd_req_idle: assert property (@(posedge clk) disable iff (!resetn)
        link.rd_req |-> !link.rd_busy);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and inspects the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aximm_stream_server \
    -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_aximm_stream_server" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG_FILE"; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// File: testbench/tb_aximm_stream_server.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench with FIFO and system memory models around the packet server
module tb_aximm_stream_server;

    localparam int DIRECTED_PACKETS = 4;
    localparam int RANDOM_PACKETS   = 40;
    localparam int TOTAL_PACKETS    = DIRECTED_PACKETS + RANDOM_PACKETS;
    localparam int RESET_CYCLES     = 16;
    localparam pkt_pkg::pkt_word_t TYPE_READ  = pkt_pkg::pkt_word_t'(pkt_pkg::PKT_READ);
    localparam pkt_pkg::pkt_word_t TYPE_WRITE = pkt_pkg::pkt_word_t'(pkt_pkg::PKT_WRITE);

    // Word 0 sits in the low bits
    typedef logic [7:0][31:0] packet_t;

    logic                 clk;
    logic                 resetn;
    bus_pkg::fifo_addr_t  fifo_addr;
    pkt_pkg::pkt_word_t   fifo_wdata;
    logic                 fifo_write;
    logic                 fifo_read;
    pkt_pkg::pkt_word_t   fifo_rdata;
    logic                 fifo_done;
    bus_pkg::sys_addr_t   sys_wr_addr;
    bus_pkg::sys_data_t   sys_wr_data;
    logic                 sys_write;
    logic                 sys_wr_done;
    bus_pkg::bus_resp_t   sys_wr_resp;
    bus_pkg::sys_addr_t   sys_rd_addr;
    logic                 sys_read;
    logic                 sys_rd_done;
    bus_pkg::sys_data_t   sys_rd_data;
    bus_pkg::bus_resp_t   sys_rd_resp;

    // Stimulus and expectations
    pkt_pkg::pkt_word_t   rx_words[$];
    pkt_pkg::pkt_word_t   tx_words[$];
    packet_t              closed_q[$];
    packet_t              exp_q[$];
    bus_pkg::sys_addr_t   exp_wr_addr[$];
    bus_pkg::sys_data_t   exp_wr_data[$];
    bus_pkg::sys_addr_t   exp_rd_addr[$];
    bus_pkg::sys_data_t   ref_mem [bus_pkg::sys_addr_t];
    bus_pkg::sys_data_t   sys_mem [bus_pkg::sys_addr_t];
    int                   responses_seen;
    string                test_name;

    // Model state
    // A delay of 0 means no access in flight
    int                   fifo_delay;
    logic                 acc_read;
    bus_pkg::fifo_addr_t  acc_addr;
    int                   wr_delay;
    int                   rd_delay;
    bus_pkg::sys_addr_t   wr_addr_hold;
    bus_pkg::sys_data_t   wr_data_hold;
    bus_pkg::sys_addr_t   rd_addr_hold;

    aximm_stream_server uut (
        .clk         (clk),
        .resetn      (resetn),
        .fifo_addr   (fifo_addr),
        .fifo_wdata  (fifo_wdata),
        .fifo_write  (fifo_write),
        .fifo_read   (fifo_read),
        .fifo_rdata  (fifo_rdata),
        .fifo_done   (fifo_done),
        .sys_wr_addr (sys_wr_addr),
        .sys_wr_data (sys_wr_data),
        .sys_write   (sys_write),
        .sys_wr_done (sys_wr_done),
        .sys_wr_resp (sys_wr_resp),
        .sys_rd_addr (sys_rd_addr),
        .sys_read    (sys_read),
        .sys_rd_done (sys_rd_done),
        .sys_rd_data (sys_rd_data),
        .sys_rd_resp (sys_rd_resp)
    );

    always #20 clk = ~clk;

    // ==========================================================================
    // Reporting
    // ==========================================================================
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: %s, expected %h, actual %h",
                                     test_name, what, expected, actual));
        end
    endtask

    // ==========================================================================
    // Reference model
    // ==========================================================================
    // Response as the packet format defines it
    // Reads see the reference memory
    function automatic packet_t expected_response(input packet_t req);
        packet_t            rsp;
        bus_pkg::sys_addr_t addr;
        rsp  = '0;
        addr = {req[1], req[2]};
        rsp[1] = req[1];
        rsp[2] = req[2];
        if (req[0] == TYPE_READ) begin
            rsp[0] = TYPE_READ;
            rsp[3] = ref_mem.exists(addr) ? ref_mem[addr] : '0;
        end else begin
            // Types 0 and 3 fall back to a write
            rsp[0] = TYPE_WRITE;
            rsp[3] = req[3];
        end
        // Upper half of the address space answers with a slave error
        rsp[4] = addr[63] ? 32'(bus_pkg::RESP_SLVERR) : 32'(bus_pkg::RESP_OKAY);
        return rsp;
    endfunction

    // Puts one request into the receive FIFO and records what should follow
    task automatic queue_packet(input pkt_pkg::pkt_word_t ptype,
                                input bus_pkg::sys_addr_t addr,
                                input bus_pkg::sys_data_t data);
        packet_t req;
        // Words 4 to 7 carry junk the server must ignore
        req = {$urandom(), $urandom(), $urandom(), $urandom(),
               data, addr[31:0], addr[63:32], ptype};
        exp_q.push_back(expected_response(req));
        if (ptype == TYPE_READ) begin
            exp_rd_addr.push_back(addr);
        end else begin
            exp_wr_addr.push_back(addr);
            exp_wr_data.push_back(data);
            if (!addr[63]) begin
                ref_mem[addr] = data;
            end
        end
        for (int i = 0; i < 8; i++) begin
            rx_words.push_back(req[i]);
        end
    endtask

    task automatic wait_responses(input int count);
        while (responses_seen < count) begin
            @(posedge clk);
        end
    endtask

    // TLR write closes the collected response
    task automatic close_response(input pkt_pkg::pkt_word_t length);
        packet_t pkt;
        check("TLR length", 32, length);
        check("TDATA words before TLR", 8, tx_words.size());
        for (int i = 0; i < 8; i++) begin
            pkt[i] = tx_words[i];
        end
        tx_words.delete();
        closed_q.push_back(pkt);
    endtask

    // ==========================================================================
    // FIFO register block model
    // ==========================================================================
    always @(posedge clk) begin
        fifo_done <= 1'b0;
        if (fifo_read || fifo_write) begin
            if (fifo_delay != 0) begin
                report_failure("FIFO access issued before the previous one completed");
            end
            acc_read = fifo_read;
            acc_addr = fifo_addr;
            if (fifo_write && fifo_addr == bus_pkg::ASF_TDATA) begin
                tx_words.push_back(fifo_wdata);
            end else if (fifo_write && fifo_addr == bus_pkg::ASF_TLR) begin
                close_response(fifo_wdata);
            end else if (fifo_write) begin
                report_failure($sformatf("FIFO write to unknown register %h", fifo_addr));
            end
            fifo_delay = 1 + int'($urandom_range(3));
        end else if (fifo_delay > 1) begin
            fifo_delay = fifo_delay - 1;
        end else if (fifo_delay == 1) begin
            fifo_delay = 0;
            fifo_rdata <= '0;
            if (acc_read && acc_addr == bus_pkg::ASF_RDFO) begin
                fifo_rdata <= pkt_pkg::pkt_word_t'(rx_words.size());
            end else if (acc_read && acc_addr == bus_pkg::ASF_RDATA) begin
                if (rx_words.size() == 0) begin
                    report_failure("RDATA read from an empty receive FIFO");
                end
                fifo_rdata <= rx_words.pop_front();
            end else if (acc_read) begin
                report_failure($sformatf("FIFO read of unknown register %h", acc_addr));
            end
            fifo_done <= 1'b1;
        end
    end

    // ==========================================================================
    // System memory model
    // ==========================================================================
    always @(posedge clk) begin
        sys_wr_done <= 1'b0;
        if (sys_write) begin
            if (wr_delay != 0 || exp_wr_addr.size() == 0) begin
                report_failure("System write issued while busy or with none expected");
            end
            check("system write address", exp_wr_addr.pop_front(), sys_wr_addr);
            check("system write data", exp_wr_data.pop_front(), sys_wr_data);
            wr_addr_hold = sys_wr_addr;
            wr_data_hold = sys_wr_data;
            wr_delay     = 1 + int'($urandom_range(5));
        end else if (wr_delay > 1) begin
            wr_delay = wr_delay - 1;
        end else if (wr_delay == 1) begin
            wr_delay = 0;
            // Error writes leave memory alone
            if (!wr_addr_hold[63]) begin
                sys_mem[wr_addr_hold] = wr_data_hold;
            end
            sys_wr_resp <= wr_addr_hold[63] ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
            sys_wr_done <= 1'b1;
        end
    end

    always @(posedge clk) begin
        sys_rd_done <= 1'b0;
        if (sys_read) begin
            if (rd_delay != 0 || exp_rd_addr.size() == 0) begin
                report_failure("System read issued while busy or with none expected");
            end
            check("system read address", exp_rd_addr.pop_front(), sys_rd_addr);
            rd_addr_hold = sys_rd_addr;
            rd_delay     = 1 + int'($urandom_range(5));
        end else if (rd_delay > 1) begin
            rd_delay = rd_delay - 1;
        end else if (rd_delay == 1) begin
            rd_delay = 0;
            sys_rd_data <= sys_mem.exists(rd_addr_hold) ? sys_mem[rd_addr_hold] : '0;
            sys_rd_resp <= rd_addr_hold[63] ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
            sys_rd_done <= 1'b1;
        end
    end

    // ==========================================================================
    // Checkers
    // ==========================================================================
    // Closed responses against the reference in order
    always @(negedge clk) begin : compare_responses
        packet_t got;
        packet_t want;
        if (closed_q.size() > 0) begin
            if (exp_q.size() == 0) begin
                report_failure("Response committed with no request outstanding");
            end
            got  = closed_q.pop_front();
            want = exp_q.pop_front();
            for (int i = 0; i < 8; i++) begin
                check($sformatf("response %0d word %0d", responses_seen, i),
                      want[i], got[i]);
            end
            responses_seen = responses_seen + 1;
        end
    end

    // Strobes stay quiet while reset is held
    always @(negedge clk) begin
        if (!resetn) begin
            check("strobes during reset", 4'b0000,
                  {fifo_read, fifo_write, sys_read, sys_write});
        end
    end

    // Budget of 400 cycles per packet
    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_PACKETS * 400) @(posedge clk);
        report_failure($sformatf("Timeout, %0d of %0d responses arrived",
                                 responses_seen, TOTAL_PACKETS));
    end

    // ==========================================================================
    // Main sequence
    // ==========================================================================
    initial begin
        pkt_pkg::pkt_word_t ptype;
        bus_pkg::sys_addr_t addr;
        void'($urandom(32'h5619_5a3b));
        clk            = 1'b0;
        resetn         = 1'b0;
        fifo_rdata     = '0;
        fifo_done      = 1'b0;
        sys_wr_done    = 1'b0;
        sys_wr_resp    = '0;
        sys_rd_done    = 1'b0;
        sys_rd_data    = '0;
        sys_rd_resp    = '0;
        fifo_delay     = 0;
        wr_delay       = 0;
        rd_delay       = 0;
        responses_seen = 0;
        test_name      = "reset";

        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        // Write, read back, then the error half of the address space
        test_name = "directed";
        @(negedge clk);
        queue_packet(TYPE_WRITE, 64'h0000_0001_0000_1000, 32'hcafe_0001);
        queue_packet(TYPE_READ,  64'h0000_0001_0000_1000, 32'h0);
        queue_packet(TYPE_WRITE, 64'h8000_0001_0000_1000, 32'hdead_beef);
        queue_packet(TYPE_READ,  64'h8000_0001_0000_1000, 32'h0);
        wait_responses(DIRECTED_PACKETS);

        // Back to back packets
        // Small address set so reads hit earlier writes
        test_name = "random";
        @(negedge clk);
        for (int n = 0; n < RANDOM_PACKETS; n++) begin
            // First two force the odd types 0 and 3
            if (n == 0) begin
                ptype = 32'd0;
            end else if (n == 1) begin
                ptype = 32'd3;
            end else begin
                ptype = $urandom_range(3);
            end
            addr = {($urandom_range(4) == 0) ? 32'h8000_0002 : 32'h0000_0002,
                    32'h0000_2000 + $urandom_range(7) * 4};
            queue_packet(ptype, addr, $urandom());
        end
        wait_responses(TOTAL_PACKETS);

        // Memory ends up holding exactly the successful writes
        test_name = "final";
        check("system memory entries", ref_mem.num(), sys_mem.num());
        foreach (ref_mem[a]) begin
            check($sformatf("memory entry %h present", a), 1, sys_mem.exists(a));
            check($sformatf("memory at %h", a), ref_mem[a], sys_mem[a]);
        end
        check("unused system writes", 0, exp_wr_addr.size());
        check("unused system reads", 0, exp_rd_addr.size());
        check("words left in receive FIFO", 0, rx_words.size());

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/pkt_pkg.sv
logic/bus_pkg.sv
logic/server_link_if.sv
logic/fifo_packet_engine.sv
logic/system_access_engine.sv
logic/aximm_stream_server.sv
testbench/tb_aximm_stream_server.sv
